/* all.f */
hdl/ntt_reorder_pkg.sv
hdl/reorder_lane.sv
hdl/reorder_loader.sv
hdl/reorder_issue.sv
hdl/ntt_reorder_top.sv
testbench/tb_clk_gen.sv
testbench/ntt_reorder_sva.sv
testbench/tb_ntt_reorder.sv

/* Bender.yml */
package:
  name: ntt_reorder

sources:
  # design, package first
  - files:
      - hdl/ntt_reorder_pkg.sv
      - hdl/reorder_lane.sv
      - hdl/reorder_loader.sv
      - hdl/reorder_issue.sv
      - hdl/ntt_reorder_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/ntt_reorder_sva.sv
      - testbench/tb_ntt_reorder.sv

/* testbench/tb_ntt_reorder.sv */
`default_nettype none

module tb_ntt_reorder;
    timeunit 1ns;
    timeprecision 1ps;

    import ntt_reorder_pkg::*;

    localparam int N_WORDS        = LANES * LANES;
    localparam int HOLD_CYCLES    = 30;
    localparam int TIMEOUT_CYCLES = 2 * (N_WORDS + 2 * LANES * 14) + 200;

    // row r is element r, column c inside it
    typedef vec_t [LANES-1:0] mat_t;

    logic  clk;
    logic  rst;
    logic  start;
    logic  serial_valid;
    word_t serial_data;
    logic  res_valid;
    vec_t  res_data;
    logic  vec_credit;
    logic  vec_valid;
    vec_t  vec_data;
    logic  vec_col;
    idx_t  vec_index;
    logic  busy;

    word_t serial_words [N_WORDS];
    vec_t  res_list [LANES];
    int    res_count;
    int    rows_seen;
    int    cols_seen;
    logic  hold_req;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    ntt_reorder_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .serial_valid (serial_valid),
        .serial_data  (serial_data),
        .res_valid    (res_valid),
        .res_data     (res_data),
        .vec_credit   (vec_credit),
        .vec_valid    (vec_valid),
        .vec_data     (vec_data),
        .vec_col      (vec_col),
        .vec_index    (vec_index),
        .busy         (busy)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_vec(input string name, input vec_t expected, input vec_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAILED at %0d ns: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_index(input string name, input idx_t expected, input idx_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAILED at %0d ns: %s expected %0d, actual %0d",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAILED at %0d ns: %s expected %b, actual %b",
                                $time, name, expected, actual));
        end
    endtask

    function automatic idx_t reverse_index(input idx_t v);
        return {v[0], v[1], v[2], v[3]};
    endfunction

    // rows: matrix after the bit-reversed load
    // cols: columns after the first n_res rows were replaced by results
    function automatic void ref_matrices(
        input  word_t words [N_WORDS],
        input  vec_t  results [LANES],
        input  int    n_res,
        output mat_t  rows,
        output mat_t  cols
    );
        mat_t m;
        idx_t outer;
        idx_t inner;
        for (int k = 0; k < N_WORDS; k++)
        begin
            outer = idx_t'(k / LANES);
            inner = idx_t'(k % LANES);
            m[reverse_index(inner)][reverse_index(outer)] = words[k];
        end
        rows = m;
        for (int r = 0; r < n_res; r++)
        begin
            m[r] = results[r];
        end
        for (int r = 0; r < LANES; r++)
        begin
            for (int c = 0; c < LANES; c++)
            begin
                cols[c][r] = m[r][c];
            end
        end
    endfunction

    task automatic run_transform(input logic with_hold);
        for (int k = 0; k < N_WORDS; k++)
        begin
            serial_words[k] = word_t'($urandom);
        end
        rows_seen = 0;
        cols_seen = 0;
        res_count = 0;
        hold_req  = with_hold;
        start     = 1'b1;
        check_flag("busy", 1'b0, busy);
        @(posedge clk);
        #1;
        start = 1'b0;
        check_flag("busy", 1'b1, busy);
        for (int k = 0; k < N_WORDS; k++)
        begin
            serial_valid = 1'b1;
            serial_data  = serial_words[k];
            @(posedge clk);
            #1;
        end
        serial_valid = 1'b0;
        while (busy)
        begin
            @(posedge clk);
            #1;
        end
        // the last column leaves after busy falls, credits trail behind
        repeat (10) @(posedge clk);
        #1;
        if ((rows_seen != LANES) || (cols_seen != LANES))
        begin
            abort_run($sformatf("run ended with %0d rows and %0d columns instead of 16 each",
                                rows_seen, cols_seen));
        end
        if (res_count != LANES)
        begin
            abort_run("the butterfly model did not return all 16 results");
        end
    endtask

    initial
    begin : stimulus
        void'($urandom(32'h7822_a39a));
        start        = 1'b0;
        serial_valid = 1'b0;
        serial_data  = '0;
        hold_req     = 1'b0;
        rows_seen    = 0;
        cols_seen    = 0;
        res_count    = 0;
        @(negedge rst);
        repeat (5)
        begin
            @(posedge clk);
            #1;
            check_flag("vec_valid", 1'b0, vec_valid);
            check_flag("busy", 1'b0, busy);
        end
        run_transform(1'b1);
        run_transform(1'b0);
        $display("*** TEST PASSED ***");
        $finish;
    end

    // takes each vector and hands its credit back 0 to 5 cycles later
    initial
    begin : consumer
        int now;
        int hold_left;
        int outstanding;
        int due_q [$];
        now         = 0;
        hold_left   = 0;
        outstanding = 0;
        vec_credit  = 1'b0;
        forever
        begin
            @(posedge clk);
            now++;
            if (vec_valid)
            begin
                if (hold_req)
                begin
                    hold_left = HOLD_CYCLES;
                    hold_req  = 1'b0;
                end
                outstanding++;
                if (outstanding > CREDITS)
                begin
                    abort_run("more vectors arrived than credits were handed out");
                end
                due_q.push_back(now + int'($urandom_range(5, 0)));
            end
            #1;
            vec_credit = 1'b0;
            if (hold_left > 0)
            begin
                hold_left--;
            end
            else if ((due_q.size() > 0) && (due_q[0] <= now))
            begin
                void'(due_q.pop_front());
                vec_credit = 1'b1;
                outstanding--;
            end
        end
    end

    // butterfly array: adds column index + 1, answers in order after 1 to 8 cycles
    initial
    begin : butterfly
        int   now;
        vec_t r;
        vec_t pend_q [$];
        int   due_q [$];
        now       = 0;
        res_valid = 1'b0;
        res_data  = '0;
        forever
        begin
            @(posedge clk);
            now++;
            if (vec_valid && !vec_col)
            begin
                for (int c = 0; c < LANES; c++)
                begin
                    r[c] = vec_data[c] + word_t'(c + 1);
                end
                pend_q.push_back(r);
                due_q.push_back(now + int'($urandom_range(8, 1)));
            end
            #1;
            res_valid = 1'b0;
            if ((pend_q.size() > 0) && (due_q[0] <= now))
            begin
                if (res_count >= LANES)
                begin
                    abort_run("more than 16 rows reached the butterfly model");
                end
                void'(due_q.pop_front());
                res_data  = pend_q.pop_front();
                res_valid = 1'b1;
                res_list[res_count] = res_data;
                res_count++;
            end
        end
    end

    initial
    begin : comparator
        mat_t exp_rows;
        mat_t exp_cols;
        logic exp_col;
        idx_t exp_idx;
        forever
        begin
            @(posedge clk);
            if (vec_valid)
            begin
                exp_col = (rows_seen == LANES);
                if (exp_col && (cols_seen == LANES))
                begin
                    abort_run("a vector arrived after all 32 of the run");
                end
                if (exp_col && (res_count != LANES))
                begin
                    abort_run("a column was sent before all 16 results were returned");
                end
                ref_matrices(serial_words, res_list, res_count, exp_rows, exp_cols);
                exp_idx = exp_col ? idx_t'(cols_seen) : idx_t'(rows_seen);
                check_flag("vec_col", exp_col, vec_col);
                check_index("vec_index", exp_idx, vec_index);
                check_vec("vec_data", exp_col ? exp_cols[exp_idx] : exp_rows[exp_idx], vec_data);
                if (exp_col)
                begin
                    cols_seen++;
                end
                else
                begin
                    rows_seen++;
                end
            end
        end
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES)
            begin
                abort_run($sformatf("the run timed out after %0d cycles", cycles));
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/ntt_reorder_sva.sv */
`default_nettype none

module ntt_reorder_sva (
    input logic                                     clk,
    input logic                                     rst,
    input logic [ntt_reorder_pkg::CRD_W-1:0]        credit_cnt,
    input logic                                     send,
    input logic                                     s1_valid,
    input logic                                     vec_credit,
    input ntt_reorder_pkg::phase_t                  phase,
    input logic                                     vec_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    import ntt_reorder_pkg::*;

    // vectors the consumer has taken and not yet given a credit back for
    int held;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            held <= 0;
        end
        else
        begin
            held <= held + int'(vec_valid) - int'(vec_credit);
        end
    end

    a_credit_max : assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CRD_W'(CREDITS))
        else $error("credit count above the consumer depth");

    // credits tied up are the ones held outside plus the two pipeline stages
    a_send_needs_credit : assert property (@(posedge clk) disable iff (rst)
        send |-> ((held + int'(s1_valid) + int'(vec_valid)) < CREDITS))
        else $error("send decided with no credit left");

    // nothing may leave while the matrix is still being filled
    a_quiet_in_load : assert property (@(posedge clk) disable iff (rst)
        (phase == PH_LOAD) |-> !vec_valid)
        else $error("vec_valid high during the load phase");

endmodule

bind reorder_issue ntt_reorder_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .credit_cnt (credit_cnt),
    .send       (send),
    .s1_valid   (s1_valid),
    .vec_credit (vec_credit),
    .phase      (phase),
    .vec_valid  (vec_valid)
);

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES = 4;

    // 8 ns period
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* hdl/ntt_reorder_top.sv */
`default_nettype none

module ntt_reorder_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   serial_valid,
    input  ntt_reorder_pkg::word_t serial_data,
    input  logic                   res_valid,
    input  ntt_reorder_pkg::vec_t  res_data,
    input  logic                   vec_credit,
    output logic                   vec_valid,
    output ntt_reorder_pkg::vec_t  vec_data,
    output logic                   vec_col,
    output ntt_reorder_pkg::idx_t  vec_index,
    output logic                   busy
);
    import ntt_reorder_pkg::*;

    phase_t               phase;
    rd_req_t              rd_req;
    lane_wr_t [LANES-1:0] lane_wr;
    vec_t                 lane_data;
    logic                 load_done;
    logic                 rows_done;

    reorder_loader u_loader (
        .clk          (clk),
        .rst          (rst),
        .phase        (phase),
        .serial_valid (serial_valid),
        .serial_data  (serial_data),
        .res_valid    (res_valid),
        .res_data     (res_data),
        .lane_wr      (lane_wr),
        .load_done    (load_done),
        .rows_done    (rows_done)
    );

    for (genvar g = 0; g < LANES; g++)
    begin : g_lane
        reorder_lane #(
            .LANE (idx_t'(g))
        ) u_lane (
            .clk     (clk),
            .lane_wr (lane_wr[g]),
            .rd_req  (rd_req),
            .rd_data (lane_data[g])
        );
    end

    reorder_issue u_issue (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .load_done  (load_done),
        .rows_done  (rows_done),
        .vec_credit (vec_credit),
        .lane_data  (lane_data),
        .phase      (phase),
        .rd_req     (rd_req),
        .vec_valid  (vec_valid),
        .vec_data   (vec_data),
        .vec_col    (vec_col),
        .vec_index  (vec_index),
        .busy       (busy)
    );

endmodule

`default_nettype wire

/* hdl/reorder_issue.sv */
`default_nettype none

module reorder_issue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     load_done,
    input  logic                     rows_done,
    input  logic                     vec_credit,
    input  ntt_reorder_pkg::vec_t    lane_data,
    output ntt_reorder_pkg::phase_t  phase,
    output ntt_reorder_pkg::rd_req_t rd_req,
    output logic                     vec_valid,
    output ntt_reorder_pkg::vec_t    vec_data,
    output logic                     vec_col,
    output ntt_reorder_pkg::idx_t    vec_index,
    output logic                     busy
);
    import ntt_reorder_pkg::*;

    idx_t             idx;
    logic             col_issued;
    logic [CRD_W-1:0] credit_cnt;
    logic             send;
    logic             last_req;

    // stage matching the lane read latency
    logic             s1_valid;
    logic             s1_col;
    logic             s1_end;
    idx_t             s1_index;

    assign send = ((phase == PH_ROW) || ((phase == PH_COL) && !col_issued))
                  && (credit_cnt != '0);
    assign last_req = send && (idx == idx_t'(LANES - 1));
    assign busy     = (phase != PH_IDLE);

    always_comb
    begin
        rd_req.en       = send;
        rd_req.col_mode = (phase == PH_COL);
        rd_req.index    = idx;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase <= PH_IDLE;
        end
        else
        begin
            case (phase)
                PH_IDLE: if (start) phase <= PH_LOAD;
                PH_LOAD: if (load_done) phase <= PH_ROW;
                PH_ROW:  if (last_req) phase <= PH_WAIT;
                PH_WAIT: if (rows_done) phase <= PH_COL;
                // leave once the last column reaches the output register
                PH_COL:  if (s1_valid && s1_end) phase <= PH_IDLE;
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // index wraps from 15 to 0, so the column pass starts at column 0
    always_ff @(posedge clk)
    begin
        if (rst || (phase == PH_IDLE))
        begin
            idx        <= '0;
            col_issued <= 1'b0;
        end
        else
        begin
            if (send)
            begin
                idx <= idx + 1'b1;
            end
            if (last_req && (phase == PH_COL))
            begin
                col_issued <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            credit_cnt <= CRD_W'(CREDITS);
        end
        else if (send && !vec_credit)
        begin
            credit_cnt <= credit_cnt - 1'b1;
        end
        else if (!send && vec_credit)
        begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_valid  <= 1'b0;
            s1_end    <= 1'b0;
            vec_valid <= 1'b0;
        end
        else
        begin
            s1_valid  <= send;
            s1_end    <= last_req && (phase == PH_COL);
            vec_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (send)
        begin
            s1_col   <= (phase == PH_COL);
            s1_index <= idx;
        end
    end

    // rows and columns unskew the same way: element n comes from lane index + n
    always_ff @(posedge clk)
    begin
        if (s1_valid)
        begin
            vec_col   <= s1_col;
            vec_index <= s1_index;
            for (int n = 0; n < LANES; n++)
            begin
                vec_data[n] <= lane_data[s1_index + idx_t'(n)];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/reorder_loader.sv */
`default_nettype none

module reorder_loader (
    input  logic                                              clk,
    input  logic                                              rst,
    input  ntt_reorder_pkg::phase_t                           phase,
    input  logic                                              serial_valid,
    input  ntt_reorder_pkg::word_t                            serial_data,
    input  logic                                              res_valid,
    input  ntt_reorder_pkg::vec_t                             res_data,
    output ntt_reorder_pkg::lane_wr_t [ntt_reorder_pkg::LANES-1:0] lane_wr,
    output logic                                              load_done,
    output logic                                              rows_done
);
    import ntt_reorder_pkg::*;

    logic [2*IDX_W-1:0] ser_cnt;
    idx_t               res_cnt;
    logic               ser_acc;
    logic               res_acc;
    idx_t               ser_row;
    idx_t               ser_col;
    idx_t               ser_lane;

    assign ser_acc = serial_valid && (phase == PH_LOAD);
    // results may come back while rows are still going out
    assign res_acc = res_valid && ((phase == PH_ROW) || (phase == PH_WAIT));

    // inner count picks the row, outer count the column
    assign ser_row  = bitrev(ser_cnt[IDX_W-1:0]);
    assign ser_col  = bitrev(ser_cnt[2*IDX_W-1:IDX_W]);
    assign ser_lane = ser_row + ser_col;

    always_comb
    begin
        idx_t src;
        for (int l = 0; l < LANES; l++)
        begin
            // lane l holds column (l - r) of row r
            src             = idx_t'(l) - res_cnt;
            lane_wr[l].en   = (ser_acc && (ser_lane == idx_t'(l))) || res_acc;
            lane_wr[l].addr = ser_acc ? ser_row : res_cnt;
            lane_wr[l].data = ser_acc ? serial_data : res_data[src];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || (phase == PH_IDLE))
        begin
            ser_cnt <= '0;
            res_cnt <= '0;
        end
        else
        begin
            if (ser_acc)
            begin
                ser_cnt <= ser_cnt + 1'b1;
            end
            if (res_acc)
            begin
                res_cnt <= res_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            load_done <= 1'b0;
            rows_done <= 1'b0;
        end
        else
        begin
            load_done <= ser_acc && (ser_cnt == '1);
            rows_done <= res_acc && (res_cnt == idx_t'(LANES - 1));
        end
    end

endmodule

`default_nettype wire

/* hdl/reorder_lane.sv */
`default_nettype none

module reorder_lane #(
    parameter ntt_reorder_pkg::idx_t LANE = '0
) (
    input  logic                      clk,
    input  ntt_reorder_pkg::lane_wr_t lane_wr,
    input  ntt_reorder_pkg::rd_req_t  rd_req,
    output ntt_reorder_pkg::word_t    rd_data
);
    import ntt_reorder_pkg::*;

    word_t mem [LANES];
    idx_t  rd_addr;

    // element (r, c) sits at address r of lane r + c
    // so column c is found at address LANE - c
    always_comb
    begin
        if (rd_req.col_mode)
        begin
            rd_addr = LANE - rd_req.index;
        end
        else
        begin
            rd_addr = rd_req.index;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lane_wr.en)
        begin
            mem[lane_wr.addr] <= lane_wr.data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_req.en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/ntt_reorder_pkg.sv */
`default_nettype none

package ntt_reorder_pkg;

    localparam int WORD_W  = 16;
    localparam int LANES   = 16;
    localparam int IDX_W   = 4;
    localparam int CREDITS = 4;

    // the counter has to hold the full value CREDITS
    localparam int CRD_W = $clog2(CREDITS + 1);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [IDX_W-1:0]  idx_t;

    // element n belongs to lane n or column n
    typedef word_t [LANES-1:0] vec_t;

    typedef struct packed {
        logic  en;
        idx_t  addr;
        word_t data;
    } lane_wr_t;

    // broadcast to all lanes, each lane derives its own address
    typedef struct packed {
        logic en;
        logic col_mode;
        idx_t index;
    } rd_req_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LOAD,
        PH_ROW,
        PH_WAIT,
        PH_COL
    } phase_t;

    function automatic idx_t bitrev(input idx_t v);
        idx_t r;
        for (int b = 0; b < IDX_W; b++)
        begin
            r[b] = v[IDX_W-1-b];
        end
        return r;
    endfunction

endpackage

`default_nettype wire
